//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - src/pipe_cfg_pkg.sv
  - src/pipe_ctrl_pkg.sv
  - src/pc_gen.sv
  - src/pipeline_control.sv
  - src/stage_reg.sv
  - src/retire_unit.sv
  - src/pipe_top.sv
  - target: sim
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_pipe_top.sv

//--- filelist.f
src/pipe_cfg_pkg.sv
src/pipe_ctrl_pkg.sv
src/pc_gen.sv
src/pipeline_control.sv
src/stage_reg.sv
src/retire_unit.sv
src/pipe_top.sv
sim/tb_clk_gen.sv
sim/tb_pipe_top.sv

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 100.0,
  parameter int      RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2.0) clk_o = ~clk_o;
  end

  // reset released just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_o = 1'b0;
  end

endmodule

//--- sim/tb_pipe_top.sv
`timescale 1ns/1ps

module tb_pipe_top;

  import pipe_cfg_pkg::*;

  localparam int          XLEN       = 32;
  localparam realtime     CLK_PERIOD = 100.0;
  localparam int          RST_CYCLES = 10;
  localparam logic [31:0] TAG        = 32'h5a5a_0000; // instr = pc ^ TAG
  // free flow, redirects, stalls, trap stall, mixed, drain
  localparam int          RUN_CYCLES = 40 + 60 + 80 + 40 + 200 + 20;
  localparam int          WDOG_CYCLES = RST_CYCLES + RUN_CYCLES + 100;

  localparam logic [1:0] SEL_SEQ  = 2'd0;
  localparam logic [1:0] SEL_HOLD = 2'd1;
  localparam logic [1:0] SEL_JUMP = 2'd2;
  localparam logic [1:0] SEL_TRAP = 2'd3;

  logic            clk, rst;
  logic            if_rdata_valid, ram_stall_if, ram_stall_mem, load_use;
  logic            jump, mul_div, trap_stall, trap_flush;
  logic [XLEN-1:0] if_rdata, jump_target, trap_vec, pc;
  logic            retire_valid;
  logic [XLEN-1:0] retire_pc, retire_instr;
  logic [31:0]     retired_count;

  int          errors = 0;
  logic [31:0] lcg_state = 32'hab37;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  pipe_top #(.XLEN(XLEN)) UUT (
    .clk                    (clk),
    .rst                    (rst),
    .if_rdata_valid_i       (if_rdata_valid),
    .ram_stall_valid_if_i   (ram_stall_if),
    .ram_stall_valid_mem_i  (ram_stall_mem),
    .load_use_valid_id_i    (load_use),
    .jump_valid_ex_i        (jump),
    .alu_mul_div_valid_ex_i (mul_div),
    .trap_stall_valid_wb_i  (trap_stall),
    .trap_flush_valid_wb_i  (trap_flush),
    .if_rdata_i             (if_rdata),
    .jump_target_i          (jump_target),
    .trap_vec_i             (trap_vec),
    .pc_o                   (pc),
    .retire_valid_o         (retire_valid),
    .retire_pc_o            (retire_pc),
    .retire_instr_o         (retire_instr),
    .retired_count_o        (retired_count)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // priority table as {pc select, stall 4..0, flush 3..0}
  function automatic logic [10:0] resolve(input logic mem_w, input logic if_w,
                                          input logic t_flush, input logic t_stall,
                                          input logic jmp, input logic md,
                                          input logic ldu, input logic rd_valid);
    if (mem_w)          return {SEL_HOLD, 5'b00111, 4'b1000};
    else if (if_w)      return {SEL_HOLD, 5'b00001, 4'b0010};
    else if (t_flush)   return {SEL_TRAP, 5'b00000, 4'b1111};
    else if (t_stall)   return {SEL_HOLD, 5'b11111, 4'b0000};
    else if (jmp)       return {SEL_JUMP, 5'b00000, 4'b0011};
    else if (md)        return {SEL_HOLD, 5'b00011, 4'b0100};
    else if (ldu)       return {SEL_HOLD, 5'b00001, 4'b0010};
    else if (!rd_valid) return {SEL_HOLD, 5'b00001, 4'b0010};
    else                return {SEL_SEQ, 5'b00000, 4'b0000};
  endfunction

  // cycle model
  logic [1:0]      exp_sel;
  logic [4:0]      exp_stall;
  logic [3:0]      exp_flush;
  logic [XLEN-1:0] m_pc;
  logic [XLEN-1:0] m_pc_hist [5]; // model pc of the last five cycles
  logic            m_v [NUM_REGS];
  logic [XLEN-1:0] m_p [NUM_REGS];
  logic [XLEN-1:0] m_i [NUM_REGS];
  logic            m_ret_v;
  logic [XLEN-1:0] m_ret_pc, m_ret_instr;
  logic [31:0]     m_count;
  logic            exp_ret_valid;
  logic            rst_q = 1'b0;
  int              quiet_cnt;

  always_comb begin
    {exp_sel, exp_stall, exp_flush} = resolve(ram_stall_mem, ram_stall_if, trap_flush,
                                              trap_stall, jump, mul_div, load_use,
                                              if_rdata_valid);
  end

  assign exp_ret_valid = m_ret_v && !exp_stall[4];

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      m_pc      <= RESET_PC;
      m_ret_v   <= 1'b0;
      m_count   <= '0;
      quiet_cnt <= 0;
      for (int k = 0; k < NUM_REGS; k++) m_v[k] <= 1'b0;
    end else begin
      quiet_cnt <= (exp_sel == SEL_SEQ) ? quiet_cnt + 1 : 0;
      case (exp_sel)
        SEL_SEQ:  m_pc <= m_pc + INSTR_STEP;
        SEL_JUMP: m_pc <= jump_target;
        SEL_TRAP: m_pc <= trap_vec;
        default:  m_pc <= m_pc;
      endcase
      m_pc_hist[0] <= m_pc;
      for (int k = 1; k < 5; k++) m_pc_hist[k] <= m_pc_hist[k-1];
      // fetch feeds register 0
      if (exp_flush[0]) begin
        m_v[0] <= 1'b0;
      end else if (!exp_stall[0]) begin
        m_v[0] <= (exp_sel == SEL_SEQ);
        m_p[0] <= m_pc;
        m_i[0] <= if_rdata;
      end
      for (int k = 1; k < NUM_REGS; k++) begin
        if (exp_flush[k]) begin
          m_v[k] <= 1'b0;
        end else if (!exp_stall[k]) begin
          m_v[k] <= m_v[k-1];
          m_p[k] <= m_p[k-1];
          m_i[k] <= m_i[k-1];
        end
      end
      if (!exp_stall[4]) begin
        m_ret_v     <= m_v[NUM_REGS-1];
        m_ret_pc    <= m_p[NUM_REGS-1];
        m_ret_instr <= m_i[NUM_REGS-1];
      end
      if (exp_ret_valid) m_count <= m_count + 32'd1;
    end
  end

  // checks
  a_reset_quiet: assert property (@(posedge clk)
    (rst && rst_q) |-> (!retire_valid && retired_count == 0)
  ) else begin
    errors++;
    $display("FAIL %0t retire_valid_o/retired_count_o expected 0/0 got %b/%0d",
             $time, $sampled(retire_valid), $sampled(retired_count));
  end

  a_reset_pc: assert property (@(posedge clk) (!rst && rst_q) |-> pc == RESET_PC)
  else begin
    errors++;
    $display("FAIL %0t pc_o expected %h got %h", $time, RESET_PC, $sampled(pc));
  end

  a_pc: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
  else begin
    errors++;
    $display("FAIL %0t pc_o expected %h got %h", $time, $sampled(m_pc), $sampled(pc));
  end

  a_ret_valid: assert property (@(posedge clk) disable iff (rst) retire_valid == exp_ret_valid)
  else begin
    errors++;
    $display("FAIL %0t retire_valid_o expected %b got %b",
             $time, $sampled(exp_ret_valid), $sampled(retire_valid));
  end

  a_ret_pc: assert property (@(posedge clk) disable iff (rst)
    exp_ret_valid |-> retire_pc == m_ret_pc
  ) else begin
    errors++;
    $display("FAIL %0t retire_pc_o expected %h got %h",
             $time, $sampled(m_ret_pc), $sampled(retire_pc));
  end

  a_ret_instr: assert property (@(posedge clk) disable iff (rst)
    exp_ret_valid |-> retire_instr == m_ret_instr
  ) else begin
    errors++;
    $display("FAIL %0t retire_instr_o expected %h got %h",
             $time, $sampled(m_ret_instr), $sampled(retire_instr));
  end

  a_count: assert property (@(posedge clk) disable iff (rst) retired_count == m_count)
  else begin
    errors++;
    $display("FAIL %0t retired_count_o expected %0d got %0d",
             $time, $sampled(m_count), $sampled(retired_count));
  end

  // five edges from pc_o to retire when nothing got in the way
  a_latency: assert property (@(posedge clk) disable iff (rst)
    (retire_valid && quiet_cnt >= 5) |-> retire_pc == m_pc_hist[4]
  ) else begin
    errors++;
    $display("FAIL %0t retire_pc_o expected %h got %h",
             $time, $sampled(m_pc_hist[4]), $sampled(retire_pc));
  end

  a_trap_freeze: assert property (@(posedge clk) disable iff (rst)
    (exp_stall == 5'b11111) |-> !retire_valid ##1 $stable(pc)
  ) else begin
    errors++;
    $display("FAIL %0t retire_valid_o/pc_o moved during trap stall, pc_o now %h",
             $time, $sampled(pc));
  end

  // allow bits: 0 mem wait, 1 fetch wait, 2 trap flush, 3 trap stall,
  // 4 jump, 5 mul/div, 6 load-use, 7 no fetch data
  task automatic drive_cycles(input int cycles, input logic [7:0] allow,
                              input logic [7:0] odds);
    logic [7:0]  req;
    logic [31:0] r;
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      #10;
      for (int b = 0; b < 8; b++) begin
        r = next_rand();
        req[b] = allow[b] && (r[23:16] < odds);
      end
      r              = next_rand();
      ram_stall_mem  = req[0];
      ram_stall_if   = req[1];
      trap_flush     = req[2];
      trap_stall     = req[3];
      jump           = req[4];
      mul_div        = req[5];
      load_use       = req[6];
      if_rdata_valid = !req[7];
      jump_target    = {16'h0000, r[31:18], 2'b00};
      trap_vec       = {16'h0001, r[17:4], 2'b00};
      if_rdata       = pc ^ TAG; // instruction memory stand-in
    end
  endtask

  initial begin
    if_rdata_valid = 1'b1;
    ram_stall_if   = 1'b0;
    ram_stall_mem  = 1'b0;
    load_use       = 1'b0;
    jump           = 1'b0;
    mul_div        = 1'b0;
    trap_stall     = 1'b0;
    trap_flush     = 1'b0;
    if_rdata       = RESET_PC ^ TAG;
    jump_target    = '0;
    trap_vec       = '0;
    wait (rst === 1'b0);
    drive_cycles(40, 8'b0000_0000, 8'd0);   // free flow
    drive_cycles(60, 8'b0001_0100, 8'd24);  // jumps and trap flushes
    drive_cycles(80, 8'b1110_0011, 8'd20);  // stalls
    drive_cycles(40, 8'b0000_1000, 8'd110); // trap stall runs
    drive_cycles(200, 8'b1111_1111, 8'd40); // overlapping requests
    drive_cycles(20, 8'b0000_0000, 8'd0);   // drain
    @(posedge clk);
    @(posedge clk);
    if (retired_count == 0) begin
      errors++;
      $display("no instruction retired during the whole run");
    end
    $display("checks done at %0t, %0d errors, %0d retired", $time, errors, retired_count);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished, %0d errors so far", errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
  parameter int XLEN = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  pipe_ctrl_pkg::pc_sel_e pc_sel_i,
  input  logic [XLEN-1:0]        jump_target_i,
  input  logic [XLEN-1:0]        trap_vec_i,
  output logic [XLEN-1:0]        pc_o,
  output logic                   fetch_valid_o
);

  import pipe_cfg_pkg::*;
  import pipe_ctrl_pkg::*;

  logic [XLEN-1:0] pc_next;

  // only a sequential step issues a new fetch
  assign fetch_valid_o = (pc_sel_i == PC_SEQ);

  always_comb begin
    case (pc_sel_i)
      PC_SEQ:  pc_next = pc_o + XLEN'(INSTR_STEP);
      PC_JUMP: pc_next = jump_target_i; // resolved in EX
      PC_TRAP: pc_next = trap_vec_i;
      default: pc_next = pc_o;          // hold
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= XLEN'(RESET_PC);
    end else begin
      pc_o <= pc_next;
    end
  end

  // jump and trap targets come from outside the core
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc_o[1:0] == 2'b00
  ) else $error("pc_gen: misaligned pc %h", pc_o);

endmodule

//--- src/pipe_cfg_pkg.sv
package pipe_cfg_pkg;

  // number of pipeline registers between fetch and retire
  // IF/ID, ID/EX, EX/MEM, MEM/WB
  localparam int NUM_REGS = 4;

  // first fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // byte increment between sequential fetches
  localparam int unsigned INSTR_STEP = 4;

endpackage

//--- src/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

  // winning hazard cause, ordered as in the priority table
  typedef enum logic [3:0] {
    HZ_NONE       = 4'd0,
    HZ_MEM_WAIT   = 4'd1,
    HZ_IF_WAIT    = 4'd2,
    HZ_TRAP_FLUSH = 4'd3,
    HZ_TRAP_STALL = 4'd4,
    HZ_JUMP       = 4'd5,
    HZ_MULDIV     = 4'd6,
    HZ_LOAD_USE   = 4'd7,
    HZ_FETCH_IDLE = 4'd8
  } hazard_e;

  // next pc source
  typedef enum logic [1:0] {
    PC_SEQ  = 2'd0,
    PC_HOLD = 2'd1,
    PC_JUMP = 2'd2,
    PC_TRAP = 2'd3
  } pc_sel_e;

  localparam int STALL_W = 5; // bits 3..0 stage regs, bit 4 retire
  localparam int FLUSH_W = 4;

  // per-cause vectors, bit k belongs to stage register k
  localparam logic [STALL_W-1:0] STALL_NONE       = 5'b00000;
  localparam logic [FLUSH_W-1:0] FLUSH_NONE       = 4'b0000;
  localparam logic [STALL_W-1:0] STALL_MEM_WAIT   = 5'b00111;
  localparam logic [FLUSH_W-1:0] FLUSH_MEM_WAIT   = 4'b1000; // bubble into MEM/WB
  localparam logic [STALL_W-1:0] STALL_IF_WAIT    = 5'b00001;
  localparam logic [FLUSH_W-1:0] FLUSH_IF_WAIT    = 4'b0010;
  localparam logic [STALL_W-1:0] STALL_TRAP_FLUSH = 5'b00000;
  localparam logic [FLUSH_W-1:0] FLUSH_TRAP_FLUSH = 4'b1111;
  localparam logic [STALL_W-1:0] STALL_TRAP_STALL = 5'b11111; // freeze everything
  localparam logic [FLUSH_W-1:0] FLUSH_TRAP_STALL = 4'b0000;
  localparam logic [STALL_W-1:0] STALL_JUMP       = 5'b00000;
  localparam logic [FLUSH_W-1:0] FLUSH_JUMP       = 4'b0011; // kill wrong-path fetches
  localparam logic [STALL_W-1:0] STALL_MULDIV     = 5'b00011;
  localparam logic [FLUSH_W-1:0] FLUSH_MULDIV     = 4'b0100;
  localparam logic [STALL_W-1:0] STALL_LOAD_USE   = 5'b00001;
  localparam logic [FLUSH_W-1:0] FLUSH_LOAD_USE   = 4'b0010;
  localparam logic [STALL_W-1:0] STALL_FETCH_IDLE = 5'b00001;
  localparam logic [FLUSH_W-1:0] FLUSH_FETCH_IDLE = 4'b0010;
  localparam logic [FLUSH_W-1:0] FLUSH_ALL        = 4'b1111; // used during reset

endpackage

//--- src/pipe_top.sv
`timescale 1ns/1ps

module pipe_top #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  // hazard requests from the decode/execute/memory stand-ins
  input  logic            if_rdata_valid_i,
  input  logic            ram_stall_valid_if_i,
  input  logic            ram_stall_valid_mem_i,
  input  logic            load_use_valid_id_i,
  input  logic            jump_valid_ex_i,
  input  logic            alu_mul_div_valid_ex_i,
  input  logic            trap_stall_valid_wb_i,
  input  logic            trap_flush_valid_wb_i,
  input  logic [XLEN-1:0] if_rdata_i,    // fetched instruction for pc_o
  input  logic [XLEN-1:0] jump_target_i,
  input  logic [XLEN-1:0] trap_vec_i,
  output logic [XLEN-1:0] pc_o,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic [XLEN-1:0] retire_instr_o,
  output logic [31:0]     retired_count_o
);

  import pipe_cfg_pkg::*;
  import pipe_ctrl_pkg::*;

  logic [STALL_W-1:0] stall;
  logic [FLUSH_W-1:0] flush;
  pc_sel_e            pc_sel;
  logic               fetch_valid;

  // slot 0 is the fetch, slot k+1 the output of register k
  logic               chain_valid [NUM_REGS+1];
  logic [XLEN-1:0]    chain_pc    [NUM_REGS+1];
  logic [XLEN-1:0]    chain_instr [NUM_REGS+1];

  assign chain_valid[0] = fetch_valid;
  assign chain_pc[0]    = pc_o;
  assign chain_instr[0] = if_rdata_i;

  pc_gen #(.XLEN(XLEN)) u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .pc_sel_i      (pc_sel),
    .jump_target_i (jump_target_i),
    .trap_vec_i    (trap_vec_i),
    .pc_o          (pc_o),
    .fetch_valid_o (fetch_valid)
  );

  pipeline_control u_ctrl (
    .clk                    (clk),
    .rst                    (rst),
    .if_rdata_valid_i       (if_rdata_valid_i),
    .ram_stall_valid_if_i   (ram_stall_valid_if_i),
    .ram_stall_valid_mem_i  (ram_stall_valid_mem_i),
    .load_use_valid_id_i    (load_use_valid_id_i),
    .jump_valid_ex_i        (jump_valid_ex_i),
    .alu_mul_div_valid_ex_i (alu_mul_div_valid_ex_i),
    .trap_stall_valid_wb_i  (trap_stall_valid_wb_i),
    .trap_flush_valid_wb_i  (trap_flush_valid_wb_i),
    .stall_o                (stall),
    .flush_o                (flush),
    .pc_sel_o               (pc_sel)
  );

  // IF/ID, ID/EX, EX/MEM, MEM/WB
  for (genvar k = 0; k < NUM_REGS; k++) begin : g_stage
    stage_reg #(.XLEN(XLEN)) u_stage_reg (
      .clk     (clk),
      .rst     (rst),
      .stall_i (stall[k]),
      .flush_i (flush[k]),
      .valid_i (chain_valid[k]),
      .pc_i    (chain_pc[k]),
      .instr_i (chain_instr[k]),
      .valid_o (chain_valid[k+1]),
      .pc_o    (chain_pc[k+1]),
      .instr_o (chain_instr[k+1])
    );
  end

  retire_unit #(.XLEN(XLEN)) u_retire (
    .clk             (clk),
    .rst             (rst),
    .stall_i         (stall[NUM_REGS]), // top stall bit
    .valid_i         (chain_valid[NUM_REGS]),
    .pc_i            (chain_pc[NUM_REGS]),
    .instr_i         (chain_instr[NUM_REGS]),
    .retire_valid_o  (retire_valid_o),
    .retire_pc_o     (retire_pc_o),
    .retire_instr_o  (retire_instr_o),
    .retired_count_o (retired_count_o)
  );

endmodule

//--- src/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
  input  logic                              clk, // assertions only
  input  logic                              rst,
  input  logic                              if_rdata_valid_i,       // fetch data present
  input  logic                              ram_stall_valid_if_i,   // fetch port busy
  input  logic                              ram_stall_valid_mem_i,  // data port busy
  input  logic                              load_use_valid_id_i,    // from ID
  input  logic                              jump_valid_ex_i,        // taken branch/jump in EX
  input  logic                              alu_mul_div_valid_ex_i, // multicycle op in EX
  input  logic                              trap_stall_valid_wb_i,  // CSR access
  input  logic                              trap_flush_valid_wb_i,  // exception/interrupt
  output logic [pipe_ctrl_pkg::STALL_W-1:0] stall_o,
  output logic [pipe_ctrl_pkg::FLUSH_W-1:0] flush_o,
  output pipe_ctrl_pkg::pc_sel_e            pc_sel_o
);

  import pipe_ctrl_pkg::*;

  hazard_e cause;

  // later stages win
  always_comb begin
    if (ram_stall_valid_mem_i) begin
      cause = HZ_MEM_WAIT;
    end else if (ram_stall_valid_if_i) begin
      cause = HZ_IF_WAIT;
    end else if (trap_flush_valid_wb_i) begin
      cause = HZ_TRAP_FLUSH;
    end else if (trap_stall_valid_wb_i) begin
      cause = HZ_TRAP_STALL;
    end else if (jump_valid_ex_i) begin
      cause = HZ_JUMP;
    end else if (alu_mul_div_valid_ex_i) begin
      cause = HZ_MULDIV;
    end else if (load_use_valid_id_i) begin
      cause = HZ_LOAD_USE;
    end else if (!if_rdata_valid_i) begin
      cause = HZ_FETCH_IDLE;
    end else begin
      cause = HZ_NONE;
    end
  end

  // cause to vectors
  always_comb begin
    stall_o  = STALL_NONE;
    flush_o  = FLUSH_NONE;
    pc_sel_o = PC_SEQ;
    if (rst) begin
      flush_o  = FLUSH_ALL; // everything empty, pc parked
      pc_sel_o = PC_HOLD;
    end else begin
      case (cause)
        HZ_MEM_WAIT: begin
          stall_o  = STALL_MEM_WAIT;
          flush_o  = FLUSH_MEM_WAIT;
          pc_sel_o = PC_HOLD;
        end
        HZ_IF_WAIT: begin
          stall_o  = STALL_IF_WAIT;
          flush_o  = FLUSH_IF_WAIT;
          pc_sel_o = PC_HOLD;
        end
        HZ_TRAP_FLUSH: begin
          stall_o  = STALL_TRAP_FLUSH;
          flush_o  = FLUSH_TRAP_FLUSH;
          pc_sel_o = PC_TRAP;
        end
        HZ_TRAP_STALL: begin
          stall_o  = STALL_TRAP_STALL;
          flush_o  = FLUSH_TRAP_STALL;
          pc_sel_o = PC_HOLD;
        end
        HZ_JUMP: begin
          stall_o  = STALL_JUMP;
          flush_o  = FLUSH_JUMP;
          pc_sel_o = PC_JUMP;
        end
        HZ_MULDIV: begin
          stall_o  = STALL_MULDIV;
          flush_o  = FLUSH_MULDIV;
          pc_sel_o = PC_HOLD;
        end
        HZ_LOAD_USE: begin
          stall_o  = STALL_LOAD_USE;
          flush_o  = FLUSH_LOAD_USE;
          pc_sel_o = PC_HOLD;
        end
        HZ_FETCH_IDLE: begin
          stall_o  = STALL_FETCH_IDLE;
          flush_o  = FLUSH_FETCH_IDLE;
          pc_sel_o = PC_HOLD;
        end
        default: ; // HZ_NONE keeps the defaults
      endcase
    end
  end

  // flush wins in the stage registers, so overlap would hide a stall
  a_no_stall_and_flush: assert property (
    @(posedge clk) disable iff (rst)
    (stall_o[FLUSH_W-1:0] & flush_o) == '0
  ) else $error("pipeline_control: stall %b overlaps flush %b", stall_o, flush_o);

  // only the two port waits outrank a trap
  a_trap_redirect: assert property (
    @(posedge clk) disable iff (rst)
    (trap_flush_valid_wb_i && !ram_stall_valid_mem_i && !ram_stall_valid_if_i)
      |-> (pc_sel_o == PC_TRAP)
  ) else $error("pipeline_control: trap flush without trap redirect");

endmodule

//--- src/retire_unit.sv
`timescale 1ns/1ps

module retire_unit #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall_i,
  input  logic            valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] instr_i,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic [XLEN-1:0] retire_instr_o,
  output logic [31:0]     retired_count_o
);

  logic ret_valid_q; // pending retirement from MEM/WB

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid_q <= 1'b0;
    end else if (!stall_i) begin
      ret_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      retire_pc_o    <= pc_i;
      retire_instr_o <= instr_i;
    end
  end

  // held back while frozen, released once the stall drops
  assign retire_valid_o = ret_valid_q && !stall_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      retired_count_o <= '0;
    end else if (retire_valid_o) begin
      retired_count_o <= retired_count_o + 32'd1;
    end
  end

endmodule

//--- src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] instr_i,
  output logic            valid_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] instr_o
);

  // valid carries the control state
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;     // bubble
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // payload only moves when the slot moves
  always_ff @(posedge clk) begin
    if (!stall_i && !flush_i) begin
      pc_o    <= pc_i;
      instr_o <= instr_i;
    end
  end

  a_flush_bubble: assert property (
    @(posedge clk) disable iff (rst)
    flush_i |=> !valid_o
  ) else $error("stage_reg: flushed stage still valid");

endmodule
